//--- build.f
source/game24_pkg.sv
source/key_receiver.sv
source/entry_checker.sv
source/expression_evaluator.sv
source/puzzle_sequencer.sv
source/solve_timer.sv
source/game24_top.sv
verification/tb_clock_gen.sv
verification/tb_game24.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_game24 -o tb_game24

output=$(./obj_dir/tb_game24 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^Test OK$"; then
    exit 0
else
    exit 1
fi

//--- verification/tb_game24.sv
`default_nettype none

module tb_game24 import game24_pkg::*;;

    typedef enum {ACT_KEYS, ACT_NEXT, ACT_RETRY} action_t;

    typedef struct {
        string       name;
        action_t     action;
        string       keys;
        game_state_t exp_state;
        int          exp_index;
        int          exp_result;
    } row_t;

    logic           clock;
    logic           rst_n;
    logic           key_req;
    scan_code_t     key_code;
    logic           key_ack;
    logic           next;
    logic           retry;
    game_state_t    game_state;
    problem_index_t problem_index;
    value_t         result;
    seconds_t       elapsed_seconds;

    row_t rows[$];
    int   cycle_count = 0;
    int   start_cycle = 0;

    tb_clock_gen #(.PERIOD(40)) i_clock_gen (.clock(clock));

    game24_top #(.TICKS_PER_SECOND(8)) i_game24_top (
        .clock, .rst_n, .key_req, .key_code, .key_ack, .next, .retry,
        .game_state, .problem_index, .result, .elapsed_seconds
    );

    task automatic fail_run(input string what);
        $display("ERROR: %s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    function automatic void add_row(input string name, input action_t action,
                                    input string keys, input game_state_t exp_state,
                                    input int exp_index, input int exp_result);
        rows.push_back('{name, action, keys, exp_state, exp_index, exp_result});
    endfunction

    // keyboard set 2 make codes
    function automatic scan_code_t scan_code_for(input byte ch);
        case (ch)
            "1": return 8'h16;
            "2": return 8'h1e;
            "3": return 8'h26;
            "4": return 8'h25;
            "5": return 8'h2e;
            "6": return 8'h36;
            "7": return 8'h3d;
            "8": return 8'h3e;
            "9": return 8'h46;
            "+": return 8'h1c;
            "-": return 8'h1b;
            "*": return 8'h3a;
            "/": return 8'h23;
            "=": return 8'h5a;
            default: return 8'hff;
        endcase
    endfunction

    // one full four-phase handshake, entered and left on a falling edge
    task automatic send_key(input byte ch);
        int waited;
        check_value("ack low before req", 0, int'(key_ack));
        key_code = scan_code_for(ch);
        key_req = 1'b1;
        waited = 0;
        while (!key_ack) begin
            @(negedge clock);
            waited++;
            if (waited > 8) fail_run("key_ack never rose after key_req went high");
        end
        // receiver must hold ack while req stays high
        @(negedge clock);
        check_value("ack held while req high", 1, int'(key_ack));
        key_req = 1'b0;
        waited = 0;
        while (key_ack) begin
            @(negedge clock);
            waited++;
            if (waited > 8) fail_run("key_ack never fell after key_req dropped");
        end
    endtask

    task automatic press_button(input action_t action);
        if (action == ACT_NEXT) begin
            next = 1'b1;
        end else begin
            retry = 1'b1;
        end
        @(negedge clock);
        next = 1'b0;
        retry = 1'b0;
    endtask

    task automatic wait_leave_problem(input string name);
        int waited;
        waited = 0;
        while (game_state == STATE_PROBLEM) begin
            @(negedge clock);
            waited++;
            if (waited > 8) fail_run({name, ": game stayed in the problem state"});
        end
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > 40 * rows.size() + 200) fail_run("run exceeded its cycle limit");
    end

    initial begin
        int     expected_seconds;
        seconds_t frozen;
        row_t   row;
        key_req = 1'b0;
        key_code = '0;
        next = 1'b0;
        retry = 1'b0;
        rst_n = 1'b0;

        add_row("start problem 0", ACT_NEXT, "", STATE_PROBLEM, 0, 0);
        add_row("wrong total", ACT_KEYS, "1+3*2+4=", STATE_FAIL, 0, 11);
        add_row("retry after fail", ACT_RETRY, "", STATE_PROBLEM, 0, 0);
        add_row("digit not given", ACT_KEYS, "5", STATE_ERROR, 0, 0);
        add_row("retry after bad digit", ACT_RETRY, "", STATE_PROBLEM, 0, 0);
        add_row("digit used twice", ACT_KEYS, "1*1", STATE_ERROR, 0, 0);
        add_row("retry after reuse", ACT_RETRY, "", STATE_PROBLEM, 0, 0);
        add_row("two operators", ACT_KEYS, "1**", STATE_ERROR, 0, 0);
        add_row("retry after operators", ACT_RETRY, "", STATE_PROBLEM, 0, 0);
        add_row("early enter", ACT_KEYS, "1*3=", STATE_ERROR, 0, 0);
        add_row("retry after enter", ACT_RETRY, "", STATE_PROBLEM, 0, 0);
        add_row("solve problem 0", ACT_KEYS, "1*3*2*4=", STATE_SUCCESS, 0, 24);
        add_row("start problem 1", ACT_NEXT, "", STATE_PROBLEM, 1, 0);
        add_row("inexact division", ACT_KEYS, "9/2", STATE_ERROR, 1, 0);
        add_row("retry after division", ACT_RETRY, "", STATE_PROBLEM, 1, 0);
        add_row("solve problem 1", ACT_KEYS, "9*3-5+2=", STATE_SUCCESS, 1, 24);
        add_row("start problem 2", ACT_NEXT, "", STATE_PROBLEM, 2, 0);
        add_row("solve problem 2", ACT_KEYS, "4*6*1*1=", STATE_CONGRATS, 2, 24);

        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_value("reset state", int'(STATE_TITLE), int'(game_state));
        check_value("reset index", 0, int'(problem_index));
        check_value("reset ack", 0, int'(key_ack));
        check_value("reset seconds", 0, int'(elapsed_seconds));

        foreach (rows[r]) begin
            row = rows[r];
            if (row.action == ACT_KEYS) begin
                for (int k = 0; k < row.keys.len(); k++) begin
                    send_key(row.keys[k]);
                end
                wait_leave_problem(row.name);
            end else begin
                // timer starts on the edge that leaves title
                if (row.action == ACT_NEXT && game_state == STATE_TITLE) begin
                    start_cycle = cycle_count + 1;
                end
                press_button(row.action);
            end
            check_value({row.name, " state"}, int'(row.exp_state), int'(game_state));
            check_value({row.name, " index"}, row.exp_index, int'(problem_index));
            check_value({row.name, " result"}, row.exp_result, int'(result));
        end

        expected_seconds = (cycle_count - start_cycle) / 8;
        if (int'(elapsed_seconds) > expected_seconds + 1 ||
            int'(elapsed_seconds) < expected_seconds - 1) begin
            check_value("timer seconds", expected_seconds, int'(elapsed_seconds));
        end
        frozen = elapsed_seconds;
        repeat (64) @(negedge clock);
        check_value("timer held in congrats", int'(frozen), int'(elapsed_seconds));

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

endmodule

`default_nettype wire

//--- source/game24_top.sv
`default_nettype none

module game24_top import game24_pkg::*; #(
    parameter int unsigned TICKS_PER_SECOND = 50_000_000
) (
    input  wire             clock,
    input  wire             rst_n,
    input  wire             key_req,
    input  wire scan_code_t key_code,
    output logic            key_ack,
    input  wire             next,
    input  wire             retry,
    output game_state_t     game_state,
    output problem_index_t  problem_index,
    output value_t          result,
    output seconds_t        elapsed_seconds
);

    token_t       token;
    logic         token_valid;
    token_t       accepted_token;
    logic         accepted_valid;
    logic         entry_error;
    logic         div_error;
    logic         eval_done;
    logic         entry_enable;
    logic         clear_entry;
    digit_t [3:0] given_digits;

    key_receiver i_key_receiver (
        .clock, .rst_n, .key_req, .key_code, .key_ack, .token, .token_valid
    );

    entry_checker i_entry_checker (
        .clock, .rst_n, .token, .token_valid, .entry_enable, .clear_entry,
        .given_digits, .accepted_token, .accepted_valid, .entry_error
    );

    expression_evaluator i_expression_evaluator (
        .clock, .rst_n, .accepted_token, .accepted_valid, .clear_entry,
        .result, .eval_done, .div_error
    );

    puzzle_sequencer i_puzzle_sequencer (
        .clock, .rst_n, .next, .retry, .entry_error, .div_error, .eval_done,
        .result, .game_state, .problem_index, .given_digits, .entry_enable,
        .clear_entry
    );

    solve_timer #(
        .TICKS_PER_SECOND(TICKS_PER_SECOND)
    ) i_solve_timer (
        .clock, .rst_n, .game_state, .elapsed_seconds
    );

endmodule

`default_nettype wire

//--- source/solve_timer.sv
`default_nettype none

module solve_timer import game24_pkg::*; #(
    parameter int unsigned TICKS_PER_SECOND = 50_000_000
) (
    input  wire              clock,
    input  wire              rst_n,
    input  wire game_state_t game_state,
    output seconds_t         elapsed_seconds
);

    localparam int TICK_WIDTH = $clog2(TICKS_PER_SECOND + 1);

    logic [TICK_WIDTH-1:0] tick_count;
    logic                  second_tick;

    assign second_tick = (tick_count == TICK_WIDTH'(TICKS_PER_SECOND - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tick_count      <= '0;
            elapsed_seconds <= '0;
        end else if (game_state == STATE_TITLE) begin
            tick_count      <= '0;
            elapsed_seconds <= '0;
        end else if (game_state != STATE_CONGRATS) begin
            if (second_tick) begin
                tick_count      <= '0;
                elapsed_seconds <= elapsed_seconds + 1'b1;
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/puzzle_sequencer.sv
`default_nettype none

module puzzle_sequencer import game24_pkg::*; (
    input  wire         clock,
    input  wire         rst_n,
    input  wire         next,
    input  wire         retry,
    input  wire         entry_error,
    input  wire         div_error,
    input  wire         eval_done,
    input  wire value_t result,
    output game_state_t      game_state,
    output problem_index_t   problem_index,
    output digit_t [3:0]     given_digits,
    output logic             entry_enable,
    output logic             clear_entry
);

    game_state_t next_state;
    logic        entry_error_q;
    logic        last_problem;

    assign last_problem = (problem_index == problem_index_t'(PROBLEM_COUNT - 1));

    always_comb begin
        next_state = game_state;
        case (game_state)
            STATE_TITLE: if (next) next_state = STATE_PROBLEM;
            STATE_PROBLEM: begin
                if (entry_error_q || div_error) begin
                    next_state = STATE_ERROR;
                end else if (eval_done) begin
                    if (result != value_t'(24)) begin
                        next_state = STATE_FAIL;
                    end else begin
                        next_state = last_problem ? STATE_CONGRATS : STATE_SUCCESS;
                    end
                end
            end
            STATE_ERROR, STATE_FAIL: if (retry) next_state = STATE_PROBLEM;
            STATE_SUCCESS: if (next || retry) next_state = STATE_PROBLEM;
            STATE_CONGRATS: next_state = STATE_CONGRATS;
            default: next_state = STATE_TITLE;
        endcase
    end

    // clears the entry on the same edge the problem state starts
    assign clear_entry  = (game_state != STATE_PROBLEM) && (next_state == STATE_PROBLEM);
    assign entry_enable = (game_state == STATE_PROBLEM);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            given_digits[i] = PROBLEM_TABLE[problem_index][i];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            game_state    <= STATE_TITLE;
            problem_index <= '0;
            entry_error_q <= 1'b0;
        end else begin
            game_state <= next_state;
            // one extra stage lines rule errors up with eval_done and div_error
            entry_error_q <= clear_entry ? 1'b0 : entry_error;
            if (game_state == STATE_SUCCESS && next) begin
                problem_index <= problem_index + 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        problem_index < problem_index_t'(PROBLEM_COUNT));

endmodule

`default_nettype wire

//--- source/expression_evaluator.sv
`default_nettype none

module expression_evaluator import game24_pkg::*; (
    input  wire         clock,
    input  wire         rst_n,
    input  wire token_t accepted_token,
    input  wire         accepted_valid,
    input  wire         clear_entry,
    output value_t      result,
    output logic        eval_done,
    output logic        div_error
);

    value_t sum;
    value_t term;
    op_t    pending_op;
    value_t digit_value;
    logic   inexact;

    assign digit_value = value_t'(accepted_token.digit);
    assign inexact     = (pending_op == OP_DIV) && ((term % digit_value) != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sum        <= '0;
            term       <= '0;
            pending_op <= OP_ADD;
            result     <= '0;
            eval_done  <= 1'b0;
            div_error  <= 1'b0;
        end else if (clear_entry) begin
            sum        <= '0;
            term       <= '0;
            pending_op <= OP_ADD;
            result     <= '0;
            eval_done  <= 1'b0;
            div_error  <= 1'b0;
        end else begin
            eval_done <= 1'b0;
            // a bad division ends the entry
            if (accepted_valid && !div_error) begin
                case (accepted_token.kind)
                    TOKEN_DIGIT: begin
                        case (pending_op)
                            OP_MUL: begin
                                term <= term * digit_value;
                            end
                            OP_DIV: begin
                                term      <= term / digit_value;
                                div_error <= inexact;
                            end
                            // add and sub open a new signed term
                            OP_SUB: begin
                                term <= -digit_value;
                            end
                            default: begin
                                term <= digit_value;
                            end
                        endcase
                    end
                    TOKEN_OP: begin
                        if (accepted_token.op == OP_ADD || accepted_token.op == OP_SUB) begin
                            sum  <= sum + term;
                            term <= '0;
                        end
                        pending_op <= accepted_token.op;
                    end
                    TOKEN_ENTER: begin
                        result    <= sum + term;
                        eval_done <= 1'b1;
                    end
                    default: begin
                        eval_done <= 1'b0;
                    end
                endcase
            end
        end
    end

    // inexact division never also yields a result
    assert property (@(posedge clock) disable iff (!rst_n) !(eval_done && div_error));

endmodule

`default_nettype wire

//--- source/entry_checker.sv
`default_nettype none

module entry_checker import game24_pkg::*; (
    input  wire               clock,
    input  wire               rst_n,
    input  wire token_t       token,
    input  wire               token_valid,
    input  wire               entry_enable,
    input  wire               clear_entry,
    input  wire digit_t [3:0] given_digits,
    output token_t            accepted_token,
    output logic              accepted_valid,
    output logic              entry_error
);

    logic       expect_digit;
    logic       entry_done;
    logic [3:0] used;
    logic [3:0] hit;
    logic [3:0] pick;
    logic       take;

    // free given slots holding the typed digit
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hit[i] = !used[i] && (given_digits[i] == token.digit);
        end
    end

    // claim only the lowest one so duplicates count separately
    assign pick = hit & (~hit + 4'd1);
    assign take = token_valid && entry_enable && !entry_done && !entry_error;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            expect_digit   <= 1'b1;
            entry_done     <= 1'b0;
            used           <= '0;
            accepted_valid <= 1'b0;
            entry_error    <= 1'b0;
        end else if (clear_entry) begin
            expect_digit   <= 1'b1;
            entry_done     <= 1'b0;
            used           <= '0;
            accepted_valid <= 1'b0;
            entry_error    <= 1'b0;
        end else begin
            accepted_valid <= 1'b0;
            if (take) begin
                case (token.kind)
                    TOKEN_DIGIT: begin
                        if (expect_digit && |hit) begin
                            used           <= used | pick;
                            expect_digit   <= 1'b0;
                            accepted_valid <= 1'b1;
                        end else begin
                            entry_error <= 1'b1;
                        end
                    end
                    TOKEN_OP: begin
                        if (!expect_digit) begin
                            expect_digit   <= 1'b1;
                            accepted_valid <= 1'b1;
                        end else begin
                            entry_error <= 1'b1;
                        end
                    end
                    TOKEN_ENTER: begin
                        if (!expect_digit && &used) begin
                            entry_done     <= 1'b1;
                            accepted_valid <= 1'b1;
                        end else begin
                            entry_error <= 1'b1;
                        end
                    end
                    default: entry_error <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            accepted_token <= token;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) accepted_valid |-> entry_enable);

endmodule

`default_nettype wire

//--- source/key_receiver.sv
`default_nettype none

module key_receiver import game24_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire             key_req,
    input  wire scan_code_t key_code,
    output logic            key_ack,
    output token_t          token,
    output logic            token_valid
);

    function automatic token_t decode_key(input scan_code_t code);
        token_t decoded;
        decoded.kind  = TOKEN_UNKNOWN;
        decoded.digit = '0;
        decoded.op    = OP_ADD;
        for (int i = 0; i < 9; i++) begin
            if (code == DIGIT_SCAN_CODES[i]) begin
                decoded.kind  = TOKEN_DIGIT;
                decoded.digit = digit_t'(i + 1);
            end
        end
        if (code == SCAN_ADD || code == SCAN_SUB || code == SCAN_MUL || code == SCAN_DIV) begin
            decoded.kind = TOKEN_OP;
            decoded.op   = (code == SCAN_ADD) ? OP_ADD :
                           (code == SCAN_SUB) ? OP_SUB :
                           (code == SCAN_MUL) ? OP_MUL : OP_DIV;
        end else if (code == SCAN_ENTER) begin
            decoded.kind = TOKEN_ENTER;
        end
        return decoded;
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            key_ack     <= 1'b0;
            token_valid <= 1'b0;
        end else begin
            token_valid <= key_req && !key_ack;
            // ack follows req in both directions
            if (key_req && !key_ack) begin
                key_ack <= 1'b1;
            end else if (!key_req && key_ack) begin
                key_ack <= 1'b0;
            end
        end
    end

    // code captured once, on the ack edge
    always_ff @(posedge clock) begin
        if (key_req && !key_ack) begin
            token <= decode_key(key_code);
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) $rose(key_ack) |-> $past(key_req));

endmodule

`default_nettype wire

//--- source/game24_pkg.sv
`default_nettype none

package game24_pkg;

    typedef logic [7:0] scan_code_t;
    typedef logic [3:0] digit_t;
    typedef logic signed [13:0] value_t;
    typedef logic [15:0] seconds_t;
    typedef logic [1:0] problem_index_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV
    } op_t;

    typedef enum logic [3:0] {
        TOKEN_DIGIT,
        TOKEN_OP,
        TOKEN_ENTER,
        TOKEN_UNKNOWN
    } token_kind_t;

    // 12 bits on the wire
    typedef struct packed {
        token_kind_t kind;
        digit_t      digit;
        op_t         op;
    } token_t;

    typedef enum logic [2:0] {
        STATE_TITLE,
        STATE_PROBLEM,
        STATE_SUCCESS,
        STATE_ERROR,
        STATE_FAIL,
        STATE_CONGRATS
    } game_state_t;

    // set 2 make codes, digit n sits at index n-1
    localparam scan_code_t DIGIT_SCAN_CODES [9] = '{
        8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46
    };
    localparam scan_code_t SCAN_ADD   = 8'h1c;
    localparam scan_code_t SCAN_SUB   = 8'h1b;
    localparam scan_code_t SCAN_MUL   = 8'h3a;
    localparam scan_code_t SCAN_DIV   = 8'h23;
    localparam scan_code_t SCAN_ENTER = 8'h5a;

    localparam int PROBLEM_COUNT = 3;

    // every row reaches 24 without brackets
    localparam digit_t PROBLEM_TABLE [PROBLEM_COUNT][4] = '{
        '{4'd1, 4'd3, 4'd2, 4'd4},
        '{4'd2, 4'd3, 4'd5, 4'd9},
        '{4'd4, 4'd6, 4'd1, 4'd1}
    };

endpackage

`default_nettype wire
